// File: all.f
common/alut_entry_pkg.sv
common/alut_ctrl_pkg.sv
alut/alut_mem.sv
alut/alut_age_checker.sv
alut/alut_addr_checker.sv
src/alut_top.sv
sim/alut_tb.sv

// File: alut/alut_addr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker
   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;
(
   input  logic                pclk18,
   input  logic                n_p_reset18,
   input  logic                learn_req,         // strobe
   input  logic                lookup_req,        // strobe
   input  logic [mac_w-1:0]    mac_addr,
   input  logic [port_w-1:0]   src_port,
   input  logic [time_w-1:0]   curr_time,
   input  logic [entry_w-1:0]  mem_read_data,
   input  logic                age_confirmed,
   input  logic                age_ok,
   input  logic                age_check_active,  // age checker busy, drop requests
   output logic [idx_w-1:0]    mem_addr,
   output logic                mem_write,
   output logic [entry_w-1:0]  mem_write_data,
   output logic                check_age,
   output logic [time_w-1:0]   last_accessed,
   output logic                add_check_active,
   output logic                learn_done,
   output logic                lookup_done,
   output logic                lookup_hit,
   output logic [port_w-1:0]   lookup_port,
   output logic                active
);

   addr_state_t        state;
   addr_state_t        nxt_state;
   logic [mac_w-1:0]   mac_q;       // latched request address
   logic [port_w-1:0]  port_q;      // src port on learn, stored port on lookup
   logic               is_learn;
   logic               accept;
   logic               hit;

   // xor of the address bytes
   function automatic logic [idx_w-1:0] fold(input logic [mac_w-1:0] mac);
      logic [idx_w-1:0] f;
      f = '0;
      for (int i = 0; i < mac_w / idx_w; i++)
         f ^= mac[i*idx_w +: idx_w];
      return f;
   endfunction

   assign accept = (state == addr_idle) && !age_check_active && (learn_req || lookup_req);
   assign hit    = mem_read_data[valid_bit] &&
                   (mem_read_data[mac_lsb +: mac_w] == mac_q);

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         addr_idle:
            if (accept)
               nxt_state = rd;
         rd:
            nxt_state = is_learn ? wr : match;
         wr:
            nxt_state = addr_idle;
         match:
            nxt_state = hit ? age_wait : addr_idle;   // miss ends here
         age_wait:
            if (age_confirmed)
               nxt_state = addr_idle;
         default:
            nxt_state = addr_idle;
      endcase
   end

   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         state <= addr_idle;
      else
         state <= nxt_state;
   end

   // request and hit payload
   always_ff @(posedge pclk18)
   begin
      if (accept)
      begin
         mac_q    <= mac_addr;
         port_q   <= src_port;
         is_learn <= learn_req;
      end
      else if (state == match && hit)
      begin
         port_q        <= mem_read_data[port_lsb +: port_w];
         last_accessed <= mem_read_data[time_lsb +: time_w];
      end
   end

   // --------------------------------------------------
   // table side and answers
   // --------------------------------------------------
   assign mem_addr       = fold(mac_q);
   assign mem_write      = (state == wr);
   assign mem_write_data = {1'b1, curr_time, port_q, mac_q};   // overwrites any old row

   assign check_age        = (state == age_wait);
   assign add_check_active = (state == age_wait);             // held with check_age

   assign learn_done  = (state == wr);
   assign lookup_done = (state == match && !hit) || (state == age_wait && age_confirmed);
   assign lookup_hit  = (state == age_wait) && age_confirmed && age_ok;
   assign lookup_port = port_q;
   assign active      = (state != addr_idle);

   a_one_req: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      !(learn_req && lookup_req));

endmodule

`default_nettype wire

// File: alut/alut_age_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker
   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;
(
   input  logic                pclk18,
   input  logic                n_p_reset18,
   input  logic [1:0]          command,           // looked at in idle only
   input  logic [7:0]          div_clk,           // tick every div_clk+1 cycles
   input  logic [entry_w-1:0]  mem_read_data,
   input  logic                check_age,         // lookup age check request
   input  logic [time_w-1:0]   last_accessed,     // stamp from the lookup hit
   input  logic [time_w-1:0]   best_bfr_age,
   input  logic                add_check_active,  // check is for the address checker
   output logic [time_w-1:0]   curr_time,
   output logic [idx_w-1:0]    mem_addr,
   output logic                mem_write,
   output logic [entry_w-1:0]  mem_write_data,
   output logic [mac_w-1:0]    lst_inv_addr,
   output logic [port_w-1:0]   lst_inv_port,
   output logic                age_confirmed,     // one cycle, qualifies age_ok
   output logic                age_ok,            // set means in date
   output logic                inval_in_prog,
   output logic                age_check_active
);

   age_state_t         state;
   age_state_t         nxt_state;
   logic [7:0]         div_cnt;
   logic [time_w-1:0]  stamp;        // stamp under test
   logic [time_w-1:0]  elapsed;      // wraps with curr_time
   logic               row_valid;

   // --------------------------------------------------
   // time base
   // --------------------------------------------------
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt == div_clk)
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   assign row_valid = mem_read_data[valid_bit];

   always_comb
   begin
      nxt_state = state;
      case (state)
         age_idle:
            if (command == cmd_inval_aged)
               nxt_state = inval_aged_rd;
            else if (command == cmd_inval_all)
               nxt_state = inval_all;
            else if (check_age && command == cmd_none)
               nxt_state = age_chk;           // lookup waits for a quiet command bus
         inval_aged_rd:
            nxt_state = age_chk;
         age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = age_idle;       // lookup answered
               else if (row_valid && !age_ok)
                  nxt_state = inval_aged_wr;  // out of date, clear it
               else if (mem_addr == max_idx)
                  nxt_state = age_idle;       // sweep done
               else
                  nxt_state = inval_aged_rd;
            end
         inval_aged_wr:
            nxt_state = (mem_addr == max_idx) ? age_idle : inval_aged_rd;
         inval_all:
            if (mem_addr == max_idx)
               nxt_state = age_idle;
         default:
            nxt_state = age_idle;
      endcase
   end

   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         state <= age_idle;
      else
         state <= nxt_state;
   end

   // --------------------------------------------------
   // table access, only ever writes zeros
   // --------------------------------------------------
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         mem_addr <= '0;
      else if (state == age_idle)
         mem_addr <= '0;                      // every sweep starts at row 0
      else if (state == inval_all || nxt_state == inval_aged_rd)
         mem_addr <= mem_addr + 1'b1;         // step to next row
   end

   assign mem_write        = (state == inval_aged_wr) || (state == inval_all);
   assign mem_write_data   = '0;
   assign age_check_active = (state != age_idle);

   // --------------------------------------------------
   // age compare
   // --------------------------------------------------
   assign stamp   = add_check_active ? last_accessed : mem_read_data[time_lsb +: time_w];
   assign elapsed = curr_time - stamp;        // modulo 2**32

   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if (state == age_chk && !age_confirmed)
      begin
         age_confirmed <= 1'b1;
         age_ok        <= (best_bfr_age > elapsed);
      end
      else
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
   end

   // --------------------------------------------------
   // sweep status and last invalidated record
   // --------------------------------------------------
   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
         inval_in_prog <= 1'b0;
      else if (state == age_idle && command == cmd_inval_aged)
         inval_in_prog <= 1'b0;               // sticky until the next aged sweep
      else if (state == inval_aged_wr)
         inval_in_prog <= 1'b1;
   end

   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (state == inval_aged_wr)
      begin
         lst_inv_addr <= mem_read_data[mac_lsb +: mac_w];
         lst_inv_port <= mem_read_data[port_lsb +: port_w];
      end
   end

   // a lookup age check may not be raised while a command sweep owns this FSM
   a_no_check_in_sweep: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      (state inside {inval_aged_rd, inval_aged_wr, inval_all}) |-> !check_age);

endmodule

`default_nettype wire

// File: alut/alut_mem.sv
`timescale 1ns/1ps
`default_nettype none

module alut_mem
   import alut_entry_pkg::*;
(
   input  logic                pclk18,
   input  logic                n_p_reset18,
   input  logic                age_owner,    // age checker holds the table
   input  logic [idx_w-1:0]    addr_age,
   input  logic                wr_age,
   input  logic [entry_w-1:0]  wdata_age,
   input  logic [idx_w-1:0]    addr_add,
   input  logic                wr_add,
   input  logic [entry_w-1:0]  wdata_add,
   output logic [entry_w-1:0]  rdata         // one cycle after the address
);

   logic [valid_bit-1:0]  payload_q [depth];  // mac, port and stamp
   logic [depth-1:0]      valid_q;            // kept apart so reset can clear it
   logic [valid_bit-1:0]  rd_payload;
   logic                  rd_valid;
   logic [idx_w-1:0]      addr;
   logic                  wr;
   logic [entry_w-1:0]    wdata;

   // owner select
   assign addr  = age_owner ? addr_age  : addr_add;
   assign wr    = age_owner ? wr_age    : wr_add;
   assign wdata = age_owner ? wdata_age : wdata_add;

   always_ff @(posedge pclk18)
   begin
      if (wr)
         payload_q[addr] <= wdata[valid_bit-1:0];
      rd_payload <= payload_q[addr];          // read before write
   end

   always_ff @(posedge pclk18 or negedge n_p_reset18)
   begin
      if (!n_p_reset18)
      begin
         valid_q  <= '0;                      // empty table
         rd_valid <= 1'b0;
      end
      else
      begin
         if (wr)
            valid_q[addr] <= wdata[valid_bit];
         rd_valid <= valid_q[addr];
      end
   end

   assign rdata = {rd_valid, rd_payload};

   // the address checker must keep its hands off while a sweep or age check runs
   a_no_add_write: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
      age_owner |-> !wr_add);

endmodule

`default_nettype wire

// File: common/alut_ctrl_pkg.sv
`default_nettype none

package alut_ctrl_pkg;

   // command bus codes, code 1 is reserved and ignored
   localparam logic [1:0] cmd_none       = 2'd0;
   localparam logic [1:0] cmd_inval_aged = 2'd2;
   localparam logic [1:0] cmd_inval_all  = 2'd3;

   // age checker FSM
   typedef enum logic [2:0] {
      age_idle      = 3'd0,
      inval_aged_rd = 3'd1,   // present next row to the table
      inval_aged_wr = 3'd2,   // clear an out of date row
      inval_all     = 3'd3,   // zero every row
      age_chk       = 3'd4    // compare a stamp against best before age
   } age_state_t;

   // address checker FSM
   typedef enum logic [2:0] {
      addr_idle = 3'd0,
      rd        = 3'd1,       // read the folded row
      wr        = 3'd2,       // learn write
      match     = 3'd3,       // lookup compare on read data
      age_wait  = 3'd4        // hit, waiting on the age checker
   } addr_state_t;

endpackage

`default_nettype wire

// File: common/alut_entry_pkg.sv
`default_nettype none

package alut_entry_pkg;

   // --------------------------------------------------
   // field widths
   // --------------------------------------------------
   localparam int mac_w   = 48;                    // ethernet address
   localparam int port_w  = 2;                     // switch port number
   localparam int time_w  = 32;                    // last access stamp
   localparam int entry_w = mac_w + port_w + time_w + 1;  // 83, incl valid flag

   // --------------------------------------------------
   // table geometry
   // --------------------------------------------------
   localparam int depth   = 256;                   // rows in the lookup table
   localparam int idx_w   = 8;                     // row index width
   localparam int max_idx = depth - 1;             // last row, ends every sweep

   // --------------------------------------------------
   // entry layout, lsb first
   // --------------------------------------------------
   // [47:0]  mac address
   // [49:48] port
   // [81:50] time of last access
   // [82]    valid
   localparam int mac_lsb   = 0;
   localparam int port_lsb  = mac_lsb + mac_w;     // 48
   localparam int time_lsb  = port_lsb + port_w;   // 50
   localparam int valid_bit = time_lsb + time_w;   // 82

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the ALUT testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module alut_tb -f all.f -o alut_sim \
   && ./obj_dir/alut_sim > sim.log 2>&1 \
   || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: sim/alut_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alut_tb
   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;
();

   localparam int n_rand_learn = 24;      // random learns in the first test
   localparam int n_rand_look  = 32;
   localparam int n_pairs      = 4;       // same index pairs
   localparam int n_aged_set   = 8;       // old entries, and as many fresh ones
   localparam int old_gap      = 250;     // idle cycles for the age test
   localparam int aged_gap     = 2000;    // idle cycles before the aged sweep
   localparam int sweep_max    = 1000;    // three cycles a row plus clears
   localparam int n_ops        = n_rand_learn + n_rand_look + 4 * n_pairs + 4
                                 + (n_rand_learn + 2 * n_pairs + 2) + 4 * n_aged_set + 2;
   localparam int cycle_limit  = 40 * n_ops + 2 * sweep_max + old_gap + aged_gap + 60;

   logic                pclk18;
   logic                n_p_reset18;
   logic                learn_req;
   logic                lookup_req;
   logic [mac_w-1:0]    mac_addr;
   logic [port_w-1:0]   src_port;
   logic                learn_done;
   logic                lookup_done;
   logic                lookup_hit;
   logic [port_w-1:0]   lookup_port;
   logic [1:0]          command;
   logic [7:0]          div_clk;
   logic [time_w-1:0]   best_bfr_age;
   logic [time_w-1:0]   curr_time;
   logic [mac_w-1:0]    lst_inv_addr;
   logic [port_w-1:0]   lst_inv_port;
   logic                inval_in_prog;
   logic                busy;

   logic [31:0]         lfsr;
   int                  errors = 0;
   int                  checks = 0;
   int                  cycles = 0;

   // reference table, written on every learn
   logic                m_valid [depth];
   logic [mac_w-1:0]    m_mac   [depth];
   logic [port_w-1:0]   m_port  [depth];
   logic [time_w-1:0]   m_time  [depth];
   logic [mac_w-1:0]    learned [$];      // addresses learned since the last clear
   int                  aged_idx [$];     // rows expected to go in the aged sweep

   alut_top alut_top_inst (
      .pclk18(pclk18), .n_p_reset18(n_p_reset18),
      .learn_req(learn_req), .lookup_req(lookup_req),
      .mac_addr(mac_addr), .src_port(src_port),
      .learn_done(learn_done), .lookup_done(lookup_done),
      .lookup_hit(lookup_hit), .lookup_port(lookup_port),
      .command(command), .div_clk(div_clk), .best_bfr_age(best_bfr_age),
      .curr_time(curr_time), .lst_inv_addr(lst_inv_addr), .lst_inv_port(lst_inv_port),
      .inval_in_prog(inval_in_prog), .busy(busy)
   );

   initial
   begin
      pclk18 = 1'b0;
      forever #4 pclk18 = ~pclk18;        // 8 ns period
   end

   // watchdog over the whole run
   always @(posedge pclk18)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout, the run went past %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [mac_w-1:0] rand_mac();
      logic [63:0] v;
      v = take_bits(mac_w);
      return v[mac_w-1:0];
   endfunction

   function automatic logic [port_w-1:0] rand_port();
      logic [63:0] v;
      v = take_bits(port_w);
      return v[port_w-1:0];
   endfunction

   // row number is the xor of the six address bytes
   function automatic logic [idx_w-1:0] index_of(input logic [mac_w-1:0] mac);
      logic [idx_w-1:0] r;
      r = mac[7:0] ^ mac[15:8] ^ mac[23:16] ^ mac[31:24] ^ mac[39:32] ^ mac[47:40];
      return r;
   endfunction

   // random address whose row is still empty in the model
   function automatic logic [mac_w-1:0] free_mac();
      logic [mac_w-1:0] mac;
      do
         mac = rand_mac();
      while (m_valid[index_of(mac)]);
      return mac;
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < sweep_max)
      begin
         @(posedge pclk18);
         #1;
         n++;
      end
      if (busy)
      begin
         errors++;
         $display("busy stayed high, no request could be made");
      end
   endtask

   task automatic do_learn(input string name, input logic [mac_w-1:0] mac,
                           input logic [port_w-1:0] port);
      int k;
      logic [idx_w-1:0] idx;
      idx = index_of(mac);
      wait_idle();
      learn_req = 1'b1;
      mac_addr  = mac;
      src_port  = port;
      @(posedge pclk18);
      #1;
      learn_req = 1'b0;
      k = 1;                               // edges since the request
      while (!learn_done && k < 40)
      begin
         @(posedge pclk18);
         #1;
         k++;
      end
      if (!learn_done)
      begin
         errors++;
         $display("%s: learn_done never came for address %h", name, mac);
      end
      else
      begin
         check_val({name, " learn latency"}, 2, k);
         m_valid[idx] = 1'b1;              // overwrite, no chaining
         m_mac[idx]   = mac;
         m_port[idx]  = port;
         m_time[idx]  = curr_time;         // stamp written at the end of this cycle
         learned.push_back(mac);
      end
   endtask

   task automatic do_lookup(input string name, input logic [mac_w-1:0] mac);
      int k;
      logic [idx_w-1:0] idx;
      logic exp_hit;
      idx = index_of(mac);
      wait_idle();
      lookup_req = 1'b1;
      mac_addr   = mac;
      @(posedge pclk18);
      #1;
      lookup_req = 1'b0;
      k = 1;
      while (!lookup_done && k < 40)
      begin
         @(posedge pclk18);
         #1;
         k++;
      end
      if (!lookup_done)
      begin
         errors++;
         $display("%s: lookup_done never came for address %h", name, mac);
      end
      else
      begin
         exp_hit = m_valid[idx] && (m_mac[idx] == mac)
                   && (best_bfr_age > curr_time - m_time[idx]);   // wraps mod 2**32
         check_val({name, " hit"}, exp_hit, lookup_hit);
         if (exp_hit)
            check_val({name, " port"}, m_port[idx], lookup_port);
         else if (!(m_valid[idx] && m_mac[idx] == mac))
            check_val({name, " miss latency"}, 2, k);   // no age check on a miss
      end
   endtask

   // one cycle command pulse, then wait for the sweep to end
   task automatic run_sweep(input string name, input logic [1:0] cmd, output int len);
      wait_idle();
      command = cmd;
      @(posedge pclk18);
      #1;
      command = cmd_none;
      len = 0;
      while (busy && len < sweep_max)
      begin
         @(posedge pclk18);
         #1;
         len++;
      end
      if (busy)
      begin
         errors++;
         $display("%s: busy never fell, the sweep did not finish", name);
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial
   begin
      logic [mac_w-1:0]  mac;
      logic [mac_w-1:0]  mac2;
      logic [time_w-1:0] t0;
      int                n;
      bit                found;

      lfsr         = 32'he38d;
      n_p_reset18  = 1'b0;
      learn_req    = 1'b0;
      lookup_req   = 1'b0;
      mac_addr     = '0;
      src_port     = '0;
      command      = cmd_none;
      div_clk      = 8'd0;                 // one time tick per cycle
      best_bfr_age = '1;                   // nothing ages
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;

      repeat (4) @(posedge pclk18);
      #1;
      n_p_reset18 = 1'b1;
      check_val("reset busy", 0, busy);
      check_val("reset learn_done", 0, learn_done);
      check_val("reset lookup_done", 0, lookup_done);
      check_val("reset inval_in_prog", 0, inval_in_prog);

      // learn random addresses, then mix known and unknown lookups
      for (int i = 0; i < n_rand_learn; i++)
         do_learn("learned", rand_mac(), rand_port());
      for (int i = 0; i < n_rand_look; i++)
      begin
         if (take_bits(1) == 64'd1)
            mac = learned[take_bits(8) % learned.size()];
         else
            mac = rand_mac();                  // most likely never learned
         do_lookup("learned", mac);
      end

      // second learn on the same row replaces the first
      for (int i = 0; i < n_pairs; i++)
      begin
         mac       = rand_mac();
         mac2      = rand_mac();
         mac2[7:0] = mac2[7:0] ^ index_of(mac2) ^ index_of(mac);   // force the same row
         do_learn("replace", mac, rand_port());
         do_learn("replace", mac2, rand_port());
         do_lookup("replace", mac);
         do_lookup("replace", mac2);
      end

      // age out with a short best before age
      best_bfr_age = 32'd50;
      mac = free_mac();
      do_learn("age", mac, rand_port());
      repeat (old_gap) @(posedge pclk18);
      #1;
      mac2 = free_mac();
      do_learn("age", mac2, rand_port());
      do_lookup("age", mac2);                  // a few cycles old, hits
      do_lookup("age", mac);                   // far past 50, misses

      // --------------------------------------------------
      // invalidate all
      // --------------------------------------------------
      run_sweep("inval_all", cmd_inval_all, n);
      check_val("inval_all length", depth, n);
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      foreach (learned[i])
         do_lookup("inval_all", learned[i]);
      learned.delete();

      // --------------------------------------------------
      // invalidate aged
      // --------------------------------------------------
      best_bfr_age = 32'd1500;                 // well over one sweep of ticks
      for (int i = 0; i < n_aged_set; i++)
         do_learn("inval_aged", free_mac(), rand_port());
      repeat (aged_gap) @(posedge pclk18);
      #1;
      for (int i = 0; i < n_aged_set; i++)
         do_learn("inval_aged", free_mac(), rand_port());
      for (int i = 0; i < depth; i++)
         if (m_valid[i] && (curr_time - m_time[i]) >= best_bfr_age)
            aged_idx.push_back(i);
      run_sweep("inval_aged", cmd_inval_aged, n);
      check_val("inval_aged in_prog", aged_idx.size() > 0, inval_in_prog);
      found = 1'b0;
      foreach (aged_idx[i])
         if (m_mac[aged_idx[i]] == lst_inv_addr && !found)
         begin
            found = 1'b1;
            check_val("inval_aged last port", m_port[aged_idx[i]], lst_inv_port);
         end
      if (!found)
      begin
         errors++;
         $display("inval_aged: last invalidated address %h is not an aged entry",
                  lst_inv_addr);
      end
      foreach (aged_idx[i])
         m_valid[aged_idx[i]] = 1'b0;
      foreach (learned[i])
         do_lookup("inval_aged", learned[i]);

      // time base, div_cnt sits at 0 while div_clk is 0
      div_clk = 8'd3;
      t0      = curr_time;
      repeat (40) @(posedge pclk18);
      #1;
      check_val("time base", t0 + 32'd10, curr_time);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/alut_top.sv
`timescale 1ns/1ps
`default_nettype none

module alut_top
   import alut_entry_pkg::*;
(
   input  logic                pclk18,
   input  logic                n_p_reset18,
   input  logic                learn_req,
   input  logic                lookup_req,
   input  logic [mac_w-1:0]    mac_addr,
   input  logic [port_w-1:0]   src_port,
   output logic                learn_done,
   output logic                lookup_done,
   output logic                lookup_hit,
   output logic [port_w-1:0]   lookup_port,
   input  logic [1:0]          command,
   input  logic [7:0]          div_clk,
   input  logic [time_w-1:0]   best_bfr_age,
   output logic [time_w-1:0]   curr_time,
   output logic [mac_w-1:0]    lst_inv_addr,
   output logic [port_w-1:0]   lst_inv_port,
   output logic                inval_in_prog,
   output logic                busy                // hold off new requests
);

   // --------------------------------------------------
   // table buses, one per checker
   // --------------------------------------------------
   logic [idx_w-1:0]    age_addr;
   logic                age_wr;
   logic [entry_w-1:0]  age_wdata;
   logic [idx_w-1:0]    add_addr;
   logic                add_wr;
   logic [entry_w-1:0]  add_wdata;
   logic [entry_w-1:0]  rdata;

   // age check handshake
   logic                check_age;
   logic                add_check_active;
   logic [time_w-1:0]   last_accessed;
   logic                age_confirmed;
   logic                age_ok;
   logic                age_check_active;
   logic                add_active;

   alut_mem u_mem (
      .pclk18(pclk18), .n_p_reset18(n_p_reset18),
      .age_owner(age_check_active),
      .addr_age(age_addr), .wr_age(age_wr), .wdata_age(age_wdata),
      .addr_add(add_addr), .wr_add(add_wr), .wdata_add(add_wdata),
      .rdata(rdata)
   );

   alut_age_checker u_age (
      .pclk18(pclk18), .n_p_reset18(n_p_reset18),
      .command(command), .div_clk(div_clk), .mem_read_data(rdata),
      .check_age(check_age), .last_accessed(last_accessed),
      .best_bfr_age(best_bfr_age), .add_check_active(add_check_active),
      .curr_time(curr_time), .mem_addr(age_addr), .mem_write(age_wr),
      .mem_write_data(age_wdata), .lst_inv_addr(lst_inv_addr),
      .lst_inv_port(lst_inv_port), .age_confirmed(age_confirmed), .age_ok(age_ok),
      .inval_in_prog(inval_in_prog), .age_check_active(age_check_active)
   );

   alut_addr_checker u_addr (
      .pclk18(pclk18), .n_p_reset18(n_p_reset18),
      .learn_req(learn_req), .lookup_req(lookup_req),
      .mac_addr(mac_addr), .src_port(src_port), .curr_time(curr_time),
      .mem_read_data(rdata), .age_confirmed(age_confirmed), .age_ok(age_ok),
      .age_check_active(age_check_active),
      .mem_addr(add_addr), .mem_write(add_wr), .mem_write_data(add_wdata),
      .check_age(check_age), .last_accessed(last_accessed),
      .add_check_active(add_check_active),
      .learn_done(learn_done), .lookup_done(lookup_done),
      .lookup_hit(lookup_hit), .lookup_port(lookup_port), .active(add_active)
   );

   assign busy = age_check_active | add_active;

endmodule

`default_nettype wire
